//--- logic/gnn_pkg.sv
/*
  Shared widths, types and packet formats for the GNN layer engine.
  Every RTL block imports this package inside its body.
*/
`default_nettype none

package gnn_pkg;

    // engine sizing
    localparam int NUM_EDGE_PE = 2;
    localparam int NUM_NODES   = 16;
    localparam int MAX_DEG     = 4;
    localparam int FEAT_W      = 16;
    // four 16-bit features summed
    localparam int ACC_W       = 19;
    localparam int WEIGHT_W    = 8;
    localparam int FRAC_BITS   = 4;
    localparam int PROD_W      = ACC_W + WEIGHT_W;
    // saturation ceiling of a result
    localparam int FEAT_MAX    = 2 ** (FEAT_W - 1) - 1;

    // apb register offsets
    localparam logic [7:0] ADDR_CTRL   = 8'h00;
    localparam logic [7:0] ADDR_WEIGHT = 8'h04;
    localparam logic [7:0] ADDR_COUNT  = 8'h08;

    typedef logic        [$clog2(NUM_NODES)-1:0] node_id_t;
    typedef logic        [2:0]                   deg_t;
    typedef logic signed [FEAT_W-1:0]            feat_t;
    typedef logic signed [ACC_W-1:0]             acc_t;
    typedef logic signed [WEIGHT_W-1:0]          weight_t;
    typedef logic signed [PROD_W-1:0]            prod_t;

    // codes follow paddr[7:6] of the memory windows
    typedef enum logic [1:0] {
        RGN_FEAT = 2'b01,
        RGN_ADJ  = 2'b10,
        RGN_RES  = 2'b11
    } mem_region_t;

    // degree in the top bits, neighbor 3 down to neighbor 0 below
    typedef struct packed {
        deg_t                   deg;
        node_id_t [MAX_DEG-1:0] nbr;
    } adj_entry_t;

    typedef struct packed {
        logic     valid;
        node_id_t node;
    } edge_task_t;

    typedef struct packed {
        logic     valid;
        logic     adj;
        node_id_t node;
    } mem_rd_req_t;

    // adjacency entry or sign-extended feature
    typedef struct packed {
        logic             valid;
        logic [ACC_W-1:0] data;
    } mem_rd_rsp_t;

    typedef struct packed {
        logic     valid;
        node_id_t node;
        acc_t     sum;
    } wb_pkt_t;

    typedef struct packed {
        logic             wr;
        mem_region_t      region;
        node_id_t         node;
        logic [ACC_W-1:0] data;
    } host_mem_t;

endpackage

`default_nettype wire

//--- logic/rr_arbiter.sv
/*
  Round-robin arbiter with a rotating priority pointer.
  The grant is one-hot and combinational; the pointer moves past the winner.
*/
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
    parameter int num_reqs = 2
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire  [num_reqs-1:0] reqs,
    output logic [num_reqs-1:0] grants
);

    // a single requester still needs a one-bit pointer
    localparam int PTR_W = (num_reqs > 1) ? $clog2(num_reqs) : 1;

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] win_idx;

    // scan from the farthest slot back to ptr so the closest request wins
    always_comb begin
        int idx;
        grants  = '0;
        win_idx = ptr;
        for (int k = num_reqs - 1; k >= 0; k--) begin
            idx = (int'(ptr) + k) % num_reqs;
            if (reqs[idx]) begin
                grants      = '0;
                grants[idx] = 1'b1;
                win_idx     = PTR_W'(idx);
            end
        end
    end

    // winner drops to lowest priority next time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (|reqs) begin
            ptr <= (win_idx == PTR_W'(num_reqs - 1)) ? '0 : win_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/gnn_ctrl.sv
/*
  APB slave, control registers and node dispatcher of the GNN engine.
  Memory windows pass through to graph_mem; a run hands node ids to idle edge PEs.
*/
`timescale 1ns/1ps
`default_nettype none

module gnn_ctrl (
    input  wire                                            clk,
    input  wire                                            rst_n,
    input  wire                                            psel,
    input  wire                                            penable,
    input  wire                                            pwrite,
    input  wire  [7:0]                                     paddr,
    input  wire  [31:0]                                    pwdata,
    output logic [31:0]                                    prdata,
    output logic                                           pready,
    output logic                                           pslverr,
    input  wire  [gnn_pkg::ACC_W-1:0]                      host_rd_data,
    output gnn_pkg::host_mem_t                             host_mem,
    output gnn_pkg::weight_t                               weight,
    output gnn_pkg::edge_task_t [gnn_pkg::NUM_EDGE_PE-1:0] edge_task,
    input  wire  [gnn_pkg::NUM_EDGE_PE-1:0]                pe_idle,
    input  wire                                            vertex_busy
);
    import gnn_pkg::*;

    typedef enum logic {ST_IDLE, ST_RUN} state_t;

    state_t                 state;
    logic                   busy;
    logic                   done;
    logic                   start;
    logic                   all_sent;
    logic                   tasks_pending;
    logic                   pipe_empty;
    node_id_t               node_last;
    node_id_t               next_id;
    logic [NUM_EDGE_PE-1:0] give;
    logic                   setup;
    logic                   access;
    logic                   mem_hit;
    logic                   reg_hit;
    logic                   mem_sel_q;
    logic [31:0]            reg_rdata_q;

    assign setup   = psel && !penable;
    assign access  = psel && penable;
    // upper three quarters of the map are memory windows
    assign mem_hit = (paddr[7:6] != 2'b00);
    assign reg_hit = (paddr == ADDR_CTRL) || (paddr == ADDR_WEIGHT) || (paddr == ADDR_COUNT);
    assign busy    = (state == ST_RUN);
    assign start   = access && pwrite && (paddr == ADDR_CTRL) && pwdata[0] && !busy;

    // zero wait states always
    assign pready  = 1'b1;
    // result window is read-only and closed while running
    assign pslverr = access && (mem_hit ? ((paddr[7:6] == RGN_RES) && (pwrite || busy))
                                        : !reg_hit);

    // address from setup on so the registered read lands in the access phase
    always_comb begin
        host_mem.wr     = access && pwrite && mem_hit && !busy && (paddr[7:6] != RGN_RES);
        host_mem.region = mem_region_t'(paddr[7:6]);
        host_mem.node   = node_id_t'(paddr[5:2]);
        host_mem.data   = pwdata[ACC_W-1:0];
    end

    assign prdata = mem_sel_q ? {{(32 - ACC_W){1'b0}}, host_rd_data} : reg_rdata_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight      <= '0;
            node_last   <= '0;
            mem_sel_q   <= 1'b0;
            reg_rdata_q <= '0;
        end else begin
            // capture register read data in setup
            if (setup) begin
                mem_sel_q <= mem_hit;
                case (paddr)
                    ADDR_CTRL:   reg_rdata_q <= {29'b0, done, busy, 1'b0};
                    ADDR_WEIGHT: reg_rdata_q <= 32'(weight);
                    ADDR_COUNT:  reg_rdata_q <= 32'(node_last);
                    default:     reg_rdata_q <= '0;
                endcase
            end
            // settings frozen during a run
            if (access && pwrite && !busy) begin
                if (paddr == ADDR_WEIGHT) weight <= weight_t'(pwdata[WEIGHT_W-1:0]);
                if (paddr == ADDR_COUNT) node_last <= node_id_t'(pwdata[3:0]);
            end
        end
    end

    // next id goes to the lowest idle PE without a queued task
    always_comb begin
        give          = '0;
        tasks_pending = 1'b0;
        for (int i = NUM_EDGE_PE - 1; i >= 0; i--) begin
            tasks_pending = tasks_pending || edge_task[i].valid;
            if (busy && !all_sent && !edge_task[i].valid && pe_idle[i]) begin
                give    = '0;
                give[i] = 1'b1;
            end
        end
    end

    // nothing left anywhere
    assign pipe_empty = all_sent && !tasks_pending && (&pe_idle) && !vertex_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            done      <= 1'b0;
            all_sent  <= 1'b0;
            next_id   <= '0;
            edge_task <= '0;
        end else begin
            // a task drops once its PE takes it
            for (int i = 0; i < NUM_EDGE_PE; i++) begin
                if (give[i]) begin
                    edge_task[i] <= '{valid: 1'b1, node: next_id};
                end else if (edge_task[i].valid && pe_idle[i]) begin
                    edge_task[i].valid <= 1'b0;
                end
            end
            if (|give) begin
                if (next_id == node_last) all_sent <= 1'b1;
                else next_id <= next_id + 1'b1;
            end
            case (state)
                ST_IDLE: if (start) begin
                    state    <= ST_RUN;
                    done     <= 1'b0;
                    all_sent <= 1'b0;
                    next_id  <= '0;
                end
                ST_RUN: if (pipe_empty) begin
                    state <= ST_IDLE;
                    done  <= 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/graph_mem.sv
/*
  Feature, adjacency and result storage of the GNN engine.
  Host port for APB, one arbitrated read port for the edge PEs, result write-back.
*/
`timescale 1ns/1ps
`default_nettype none

module graph_mem (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire gnn_pkg::host_mem_t     host_mem,
    output logic [gnn_pkg::ACC_W-1:0]   host_rd_data,
    input  wire gnn_pkg::mem_rd_req_t   rd_req,
    output gnn_pkg::mem_rd_rsp_t        rd_rsp,
    input  wire gnn_pkg::wb_pkt_t       result_wr
);
    import gnn_pkg::*;

    feat_t      feat_mem [NUM_NODES];
    adj_entry_t adj_mem  [NUM_NODES];
    feat_t      res_mem  [NUM_NODES];

    feat_t      feat_q;
    adj_entry_t adj_q;
    logic       rd_valid_q;
    logic       rd_adj_q;

    // host and result writes never overlap, ctrl locks out the host while busy
    always_ff @(posedge clk) begin
        if (host_mem.wr && (host_mem.region == RGN_FEAT)) begin
            feat_mem[host_mem.node] <= feat_t'(host_mem.data[FEAT_W-1:0]);
        end
        if (host_mem.wr && (host_mem.region == RGN_ADJ)) begin
            adj_mem[host_mem.node] <= adj_entry_t'(host_mem.data);
        end
        if (result_wr.valid) begin
            res_mem[result_wr.node] <= feat_t'(result_wr.sum[FEAT_W-1:0]);
        end
    end

    // host read, one cycle
    always_ff @(posedge clk) begin
        case (host_mem.region)
            RGN_ADJ: host_rd_data <= adj_mem[host_mem.node];
            RGN_RES: host_rd_data <= {{(ACC_W - FEAT_W){res_mem[host_mem.node][FEAT_W-1]}},
                                      res_mem[host_mem.node]};
            default: host_rd_data <= {{(ACC_W - FEAT_W){feat_mem[host_mem.node][FEAT_W-1]}},
                                      feat_mem[host_mem.node]};
        endcase
    end

    // engine read port, both arrays read every cycle
    always_ff @(posedge clk) begin
        feat_q <= feat_mem[rd_req.node];
        adj_q  <= adj_mem[rd_req.node];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
            rd_adj_q   <= 1'b0;
        end else begin
            rd_valid_q <= rd_req.valid;
            rd_adj_q   <= rd_req.adj;
        end
    end

    // features go out sign-extended to the sum width
    assign rd_rsp.valid = rd_valid_q;
    assign rd_rsp.data  = rd_adj_q ? adj_q : {{(ACC_W - FEAT_W){feat_q[FEAT_W-1]}}, feat_q};

endmodule

`default_nettype wire

//--- logic/edge_pe.sv
/*
  Edge processing element: sums the features of one node's neighbors.
  Reads the adjacency entry, then each neighbor, then offers the sum for write-back.
*/
`timescale 1ns/1ps
`default_nettype none

module edge_pe (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire gnn_pkg::edge_task_t    edge_task,
    output logic                        idle,
    output gnn_pkg::mem_rd_req_t        rd_req,
    input  wire                         rd_grant,
    input  wire gnn_pkg::mem_rd_rsp_t   rd_rsp,
    output gnn_pkg::wb_pkt_t            wb,
    input  wire                         wb_grant
);
    import gnn_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH_ADJ,
        ST_WAIT_ADJ,
        ST_FETCH_NBR,
        ST_WAIT_NBR,
        ST_WB
    } state_t;

    state_t     state;
    node_id_t   node;
    adj_entry_t adj;
    adj_entry_t rsp_adj;
    deg_t       nbr_idx;
    acc_t       acc;

    assign idle    = (state == ST_IDLE);
    assign rsp_adj = adj_entry_t'(rd_rsp.data);

    // request held steady in the fetch states until granted
    always_comb begin
        rd_req = '0;
        case (state)
            ST_FETCH_ADJ: rd_req = '{valid: 1'b1, adj: 1'b1, node: node};
            ST_FETCH_NBR: rd_req = '{valid: 1'b1, adj: 1'b0, node: adj.nbr[nbr_idx]};
            default:      rd_req = '0;
        endcase
    end

    assign wb = '{valid: (state == ST_WB), node: node, sum: acc};

    // node id and adjacency entry
    always_ff @(posedge clk) begin
        if (idle && edge_task.valid) node <= edge_task.node;
        if ((state == ST_WAIT_ADJ) && rd_rsp.valid) adj <= rsp_adj;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            nbr_idx <= '0;
            acc     <= '0;
        end else begin
            case (state)
                ST_IDLE: if (edge_task.valid) begin
                    acc     <= '0;
                    nbr_idx <= '0;
                    state   <= ST_FETCH_ADJ;
                end
                ST_FETCH_ADJ: if (rd_grant) state <= ST_WAIT_ADJ;
                // degree 0 goes straight out with a zero sum
                ST_WAIT_ADJ: if (rd_rsp.valid) begin
                    state <= (rsp_adj.deg == '0) ? ST_WB : ST_FETCH_NBR;
                end
                ST_FETCH_NBR: if (rd_grant) state <= ST_WAIT_NBR;
                ST_WAIT_NBR: if (rd_rsp.valid) begin
                    acc <= acc + acc_t'(rd_rsp.data);
                    if (nbr_idx + 1'b1 == adj.deg) begin
                        state <= ST_WB;
                    end else begin
                        nbr_idx <= nbr_idx + 1'b1;
                        state   <= ST_FETCH_NBR;
                    end
                end
                ST_WB: if (wb_grant) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/vertex_pe.sv
/*
  Vertex processing element, a two-stage pipeline that never stalls.
  Scales a sum by the weight, applies ReLU and saturates into the result region.
*/
`timescale 1ns/1ps
`default_nettype none

module vertex_pe (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire gnn_pkg::wb_pkt_t   wb_in,
    input  wire gnn_pkg::weight_t   weight,
    output gnn_pkg::wb_pkt_t        result_wr,
    output logic                    busy
);
    import gnn_pkg::*;

    logic     s1_valid;
    node_id_t s1_node;
    prod_t    s1_prod;
    prod_t    scaled;
    feat_t    clipped;
    logic     s2_valid;
    node_id_t s2_node;
    feat_t    s2_val;

    // stage 1 full signed product
    always_ff @(posedge clk) begin
        s1_node <= wb_in.node;
        s1_prod <= $signed(wb_in.sum) * $signed(weight);
    end

    // drop the fraction bits, then relu and clamp
    always_comb begin
        scaled = s1_prod >>> FRAC_BITS;
        if (scaled < 0) begin
            clipped = '0;
        end else if (scaled > FEAT_MAX) begin
            clipped = feat_t'(FEAT_MAX);
        end else begin
            clipped = feat_t'(scaled);
        end
    end

    // stage 2 result
    always_ff @(posedge clk) begin
        s2_node <= s1_node;
        s2_val  <= clipped;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= wb_in.valid;
            s2_valid <= s1_valid;
        end
    end

    assign result_wr = '{valid: s2_valid, node: s2_node, sum: acc_t'(s2_val)};
    assign busy      = s1_valid || s2_valid;

endmodule

`default_nettype wire

//--- logic/gnn_accel.sv
/*
  Top level of the GNN layer engine with its APB host port.
  Ties the controller, graph memory, edge PEs, both arbiters and the vertex PE.
*/
`timescale 1ns/1ps
`default_nettype none

module gnn_accel (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [7:0]  paddr,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    import gnn_pkg::*;

    host_mem_t                     host_mem;
    logic [ACC_W-1:0]              host_rd_data;
    weight_t                       weight;
    edge_task_t [NUM_EDGE_PE-1:0]  edge_task;
    logic [NUM_EDGE_PE-1:0]        pe_idle;
    logic                          vertex_busy;
    mem_rd_req_t [NUM_EDGE_PE-1:0] pe_rd_req;
    mem_rd_rsp_t [NUM_EDGE_PE-1:0] pe_rd_rsp;
    wb_pkt_t [NUM_EDGE_PE-1:0]     pe_wb;
    logic [NUM_EDGE_PE-1:0]        rd_reqs;
    logic [NUM_EDGE_PE-1:0]        rd_grants;
    logic [NUM_EDGE_PE-1:0]        rd_grant_q;
    logic [NUM_EDGE_PE-1:0]        wb_reqs;
    logic [NUM_EDGE_PE-1:0]        wb_grants;
    mem_rd_req_t                   rd_req;
    mem_rd_rsp_t                   rd_rsp;
    wb_pkt_t                       wb_sel;
    wb_pkt_t                       result_wr;

    // winners onto the shared read port and write-back path
    always_comb begin
        rd_req = '0;
        wb_sel = '0;
        for (int i = 0; i < NUM_EDGE_PE; i++) begin
            rd_reqs[i] = pe_rd_req[i].valid;
            wb_reqs[i] = pe_wb[i].valid;
            if (rd_grants[i]) rd_req = pe_rd_req[i];
            if (wb_grants[i]) wb_sel = pe_wb[i];
            // response belongs to last cycle's winner
            pe_rd_rsp[i]       = rd_rsp;
            pe_rd_rsp[i].valid = rd_rsp.valid && rd_grant_q[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) rd_grant_q <= '0;
        else rd_grant_q <= rd_grants;
    end

    gnn_ctrl gnn_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .host_rd_data (host_rd_data),
        .host_mem     (host_mem),
        .weight       (weight),
        .edge_task    (edge_task),
        .pe_idle      (pe_idle),
        .vertex_busy  (vertex_busy)
    );

    graph_mem graph_mem_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .host_mem     (host_mem),
        .host_rd_data (host_rd_data),
        .rd_req       (rd_req),
        .rd_rsp       (rd_rsp),
        .result_wr    (result_wr)
    );

    for (genvar i = 0; i < NUM_EDGE_PE; i++) begin : g_edge_pe
        edge_pe edge_pe_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .edge_task (edge_task[i]),
            .idle      (pe_idle[i]),
            .rd_req    (pe_rd_req[i]),
            .rd_grant  (rd_grants[i]),
            .rd_rsp    (pe_rd_rsp[i]),
            .wb        (pe_wb[i]),
            .wb_grant  (wb_grants[i])
        );
    end

    rr_arbiter #(.num_reqs(NUM_EDGE_PE)) rd_arbiter (
        .clk    (clk),
        .rst_n  (rst_n),
        .reqs   (rd_reqs),
        .grants (rd_grants)
    );

    rr_arbiter #(.num_reqs(NUM_EDGE_PE)) wb_arbiter (
        .clk    (clk),
        .rst_n  (rst_n),
        .reqs   (wb_reqs),
        .grants (wb_grants)
    );

    vertex_pe vertex_pe_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_in     (wb_sel),
        .weight    (weight),
        .result_wr (result_wr),
        .busy      (vertex_busy)
    );

endmodule

`default_nettype wire

//--- dv/gnn_accel_asserts.sv
/*
  Concurrent checks on the arbiters, the shared read port and the run status.
  Bound into the top level; every failure raises $error and bumps fail_count.
*/
`timescale 1ns/1ps
`default_nettype none

module gnn_accel_asserts (
    input wire                                                  clk,
    input wire                                                  rst_n,
    input wire [gnn_pkg::NUM_EDGE_PE-1:0]                       rd_grants,
    input wire [gnn_pkg::NUM_EDGE_PE-1:0]                       wb_grants,
    input wire gnn_pkg::mem_rd_req_t [gnn_pkg::NUM_EDGE_PE-1:0] pe_rd_req,
    input wire gnn_pkg::wb_pkt_t [gnn_pkg::NUM_EDGE_PE-1:0]     pe_wb,
    input wire gnn_pkg::mem_rd_rsp_t                            rd_rsp,
    input wire                                                  run_busy,
    input wire                                                  run_done
);

    // failures seen so far
    int fail_count = 0;

    // at most one winner on each shared path
    a_rd_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rd_grants))
        else begin
            fail_count++;
            $error("read arbiter granted more than one PE");
        end

    a_wb_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(wb_grants))
        else begin
            fail_count++;
            $error("write-back arbiter granted more than one PE");
        end

    // a losing requester keeps its request as it was
    for (genvar i = 0; i < gnn_pkg::NUM_EDGE_PE; i++) begin : g_hold
        a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
            pe_rd_req[i].valid && !rd_grants[i] |=> $stable(pe_rd_req[i]))
            else begin
                fail_count++;
                $error("read request of PE %0d changed before its grant", i);
            end

        a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
            pe_wb[i].valid && !wb_grants[i] |=> $stable(pe_wb[i]))
            else begin
                fail_count++;
                $error("write-back packet of PE %0d changed before its grant", i);
            end
    end

    // response exactly one cycle after a grant, never without one
    a_rsp_after_grant: assert property (@(posedge clk) disable iff (!rst_n)
        (|rd_grants) |=> rd_rsp.valid)
        else begin
            fail_count++;
            $error("no read response one cycle after a grant");
        end

    a_rsp_needs_grant: assert property (@(posedge clk) disable iff (!rst_n)
        rd_rsp.valid |-> $past(|rd_grants))
        else begin
            fail_count++;
            $error("read response without a grant in the previous cycle");
        end

    a_done_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(run_done && run_busy))
        else begin
            fail_count++;
            $error("done and busy high together");
        end

endmodule

bind gnn_accel gnn_accel_asserts gnn_accel_asserts_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_grants (rd_grants),
    .wb_grants (wb_grants),
    .pe_rd_req (pe_rd_req),
    .pe_wb     (pe_wb),
    .rd_rsp    (rd_rsp),
    .run_busy  (gnn_ctrl_i.busy),
    .run_done  (gnn_ctrl_i.done)
);

`default_nettype wire

//--- dv/gnn_accel_tb.sv
/*
  Testbench for the GNN layer engine, driving it only through APB.
  Loads random and directed graphs, runs layers and compares every result
  with a software model of aggregate, scale, ReLU and saturation.
*/
`timescale 1ns/1ps
`default_nettype none

module gnn_accel_tb;
    import gnn_pkg::*;

    localparam int CLK_PERIOD = 100;
    // 20 runs of 16 nodes at about 12 cycles each, plus APB traffic
    localparam int WATCHDOG_CYCLES = 20 * 16 * 12 + 4000;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // graph image kept on the tb side
    int feat [NUM_NODES];
    int deg  [NUM_NODES];
    int nbr  [NUM_NODES][MAX_DEG];
    int checks;
    int errors;

    gnn_accel gnn_accel_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // setup then access, response sampled mid access
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        // zero wait states on every transfer
        check_equal("pready", pready, 1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_access(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic check_equal(input string what, input longint got, input longint exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Mismatch at time %0t: %s read %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // sum of neighbors, times weight, fraction bits dropped, relu, saturate
    function automatic int model_result(input int node, input int w);
        longint sum;
        longint scaled;
        sum = 0;
        for (int k = 0; k < deg[node]; k++) begin
            sum += feat[nbr[node][k]];
        end
        scaled = (sum * w) >>> FRAC_BITS;
        if (scaled < 0) return 0;
        if (scaled > 32767) return 32767;
        return int'(scaled);
    endfunction

    task automatic random_graph(input int fmin, input int fmax);
        for (int n = 0; n < NUM_NODES; n++) begin
            feat[n] = fmin + int'($urandom_range(fmax - fmin));
            deg[n]  = int'($urandom_range(MAX_DEG));
            // self loops and repeats allowed
            for (int k = 0; k < MAX_DEG; k++) begin
                nbr[n][k] = int'($urandom_range(NUM_NODES - 1));
            end
        end
    endtask

    task automatic load_graph();
        logic        err;
        logic [31:0] adj_word;
        for (int n = 0; n < NUM_NODES; n++) begin
            apb_write(8'h40 + 8'(4 * n), 32'(feat[n]) & 32'h0000_ffff, err);
            check_equal("pslverr on feature write", err, 0);
            // degree at bit 16, neighbor k in nibble k
            adj_word = 32'(deg[n]) << 16;
            for (int k = 0; k < MAX_DEG; k++) begin
                adj_word |= 32'(nbr[n][k]) << (4 * k);
            end
            apb_write(8'h80 + 8'(4 * n), adj_word, err);
            check_equal("pslverr on adjacency write", err, 0);
        end
    endtask

    task automatic run_layer(input int w, input int last, input bit probe_busy);
        logic        err;
        logic [31:0] rdata;
        apb_write(ADDR_WEIGHT, 32'(w) & 32'h0000_00ff, err);
        apb_write(ADDR_COUNT, 32'(last), err);
        apb_write(ADDR_CTRL, 32'h1, err);
        // busy set and done cleared right after start
        apb_read(ADDR_CTRL, rdata, err);
        check_equal("status after start", rdata[2:1], 2'b01);
        if (probe_busy) begin
            apb_read(8'hc0, rdata, err);
            check_equal("pslverr on result read while busy", err, 1);
        end
        // poll for done
        do begin
            apb_read(ADDR_CTRL, rdata, err);
        end while (!rdata[2]);
        for (int n = 0; n <= last; n++) begin
            apb_read(8'hc0 + 8'(4 * n), rdata, err);
            check_equal($sformatf("result of node %0d", n), rdata, model_result(n, w));
        end
    endtask

    initial begin
        logic        err;
        logic [31:0] rdata;
        clk     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        checks  = 0;
        errors  = 0;
        void'($urandom(24));
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle after reset, registers, error responses
        apb_read(ADDR_CTRL, rdata, err);
        check_equal("status after reset", rdata, 0);
        apb_write(ADDR_WEIGHT, 32'h35, err);
        apb_write(ADDR_COUNT, 32'h9, err);
        apb_read(ADDR_WEIGHT, rdata, err);
        check_equal("weight readback", rdata, 32'h35);
        apb_read(ADDR_COUNT, rdata, err);
        check_equal("node count readback", rdata, 9);
        apb_write(8'hc4, 32'h1234, err);
        check_equal("pslverr on result write", err, 1);
        apb_read(8'h0c, rdata, err);
        check_equal("pslverr on unmapped read", err, 1);
        apb_write(8'h20, 32'h0, err);
        check_equal("pslverr on unmapped write", err, 1);

        // random graph, positive weight
        random_graph(-2000, 2000);
        load_graph();
        run_layer(23, NUM_NODES - 1, 1'b0);

        // isolated node 0, node 1 twice its own neighbor
        deg[0]    = 0;
        deg[1]    = 3;
        nbr[1][0] = 1;
        nbr[1][1] = 1;
        nbr[1][2] = 0;
        load_graph();
        run_layer(16, NUM_NODES - 1, 1'b0);

        // negative weight, relu clamps to zero
        random_graph(1, 3000);
        load_graph();
        run_layer(-5, NUM_NODES - 1, 1'b0);

        // large features, saturation
        random_graph(30000, 32767);
        load_graph();
        run_layer(127, NUM_NODES - 1, 1'b0);

        // result window closed while running
        random_graph(-1000, 3000);
        load_graph();
        run_layer(40, NUM_NODES - 1, 1'b1);

        // back to back, new weight and count each time
        repeat (3) begin
            run_layer(int'($urandom_range(60)) + 1, int'($urandom_range(12)) + 3, 1'b0);
        end

        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 checks, errors, gnn_accel_i.gnn_accel_asserts_i.fail_count);
        if (errors == 0 && gnn_accel_i.gnn_accel_asserts_i.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // hang guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: tests did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- gnn_accel.f
logic/gnn_pkg.sv
logic/rr_arbiter.sv
logic/gnn_ctrl.sv
logic/graph_mem.sv
logic/edge_pe.sv
logic/vertex_pe.sv
logic/gnn_accel.sv
dv/gnn_accel_asserts.sv
dv/gnn_accel_tb.sv

//--- Bender.yml
package:
  name: gnn_accel

sources:
  # rtl in compile order
  - logic/gnn_pkg.sv
  - logic/rr_arbiter.sv
  - logic/gnn_ctrl.sv
  - logic/graph_mem.sv
  - logic/edge_pe.sv
  - logic/vertex_pe.sv
  - logic/gnn_accel.sv
  - target: test
    files:
      - dv/gnn_accel_asserts.sv
      - dv/gnn_accel_tb.sv
